//--- filelist.f
hw/halfFloatPkg.sv
hw/accumPkg.sv
hw/fpAddAlign.sv
hw/fpAddNormalize.sv
hw/fpAddRound.sv
hw/fpAddPipe.sv
hw/accumController.sv
hw/vectorAccum.sv
sim/vectorAccumTb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the vectorAccum testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal -f filelist.f --top-module vectorAccumTb -o vsim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/vsim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
	exit 0
else
	echo "Pass message not found in $LOG"
	exit 1
fi

//--- sim/accumInput.txt
# Columns: eight binary16 input words in address order, then the expected sum
# All hex, sums are ordered additions from +0 with round to nearest even
3C00 4000 4200 4400 4500 4600 4700 4800 5080
4900 C200 3800 B400 4000 BC00 3000 4400 4A30
3C00 BC00 4000 C000 4200 C200 4400 C400 0000
6800 3C00 3C00 3C00 3C00 3C00 3C00 4200 6802
3A00 3E00 B800 5640 D240 3400 B000 6400 6434
3D00 3D00 3D00 3D00 3D00 3D00 3D00 3D00 4900
C700 3C00 3C00 3C00 CC00 3800 3400 3000 CCC8
3C00 1001 1000 0C00 BC00 1800 3C00 4000 4202

//--- sim/vectorAccumTb.sv
`timescale 1ns/1ps

module vectorAccumTb;
	localparam int NumElems = 8;
	localparam int MaxLines = 32;
	localparam int RunCycles = 1 + NumElems * accumPkg::ElemCycles; // Start to done

	logic ap_clk;
	logic ap_rst;
	logic apStart;
	logic apContinue;
	logic apDone;
	logic apIdle;
	logic apReady;
	accumPkg::memReqT memReq;
	halfFloatPkg::halfT memData;
	halfFloatPkg::halfT result;
	logic resultValid;

	logic [15:0] inWords [0:MaxLines-1][0:NumElems-1];
	logic [15:0] expSum [0:MaxLines-1];
	logic [15:0] mem [0:15]; // Memory model behind memReq
	int numLines;
	int curLine;
	int errors;
	int runsSeen; // resultValid pulses
	int cycle;
	int limit;
	int startCycle;
	int expectAddr;
	logic busy; // A run was accepted and has not ended
	logic donePend; // Done seen and not yet acknowledged
	logic readPending = 1'b0;
	logic [3:0] readAddr;
	logic [31:0] lfsr;

	vectorAccum #(
		.NumElems(NumElems)
	) uut (
		.ap_clk(ap_clk),
		.ap_rst(ap_rst),
		.apStart(apStart),
		.apContinue(apContinue),
		.apDone(apDone),
		.apIdle(apIdle),
		.apReady(apReady),
		.memReq(memReq),
		.memData(memData),
		.result(result),
		.resultValid(resultValid)
	);

	initial begin
		ap_clk = 1'b0;
		forever #5 ap_clk = ~ap_clk;
	end

	// Feedback from taps 32 22 2 1 enters at the LSB
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic readVectors();
		int fd;
		int code;
		string line;
		logic [15:0] t [0:8];
		numLines = 0;
		fd = $fopen("sim/accumInput.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the stimulus file sim/accumInput.txt");
		end else begin
			while (!$feof(fd) && numLines < MaxLines) begin
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 1 && line[0] != "#") begin
					code = $sscanf(line, "%h %h %h %h %h %h %h %h %h", t[0], t[1], t[2],
						t[3], t[4], t[5], t[6], t[7], t[8]);
					if (code == 9) begin
						for (int k = 0; k < NumElems; k++) begin
							inWords[numLines][k] = t[k];
						end
						expSum[numLines] = t[8];
						numLines++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Unused addresses get an address-dependent pattern
	task automatic loadMemory(input int ln);
		logic [3:0] a;
		for (int k = 0; k < 16; k++) begin
			a = k[3:0];
			mem[k] = (k < NumElems) ? inWords[ln][k] : {a, ~a, a, ~a};
		end
	endtask

	task automatic checkIdleState();
		assert (apDone === 1'b0) else begin
			errors++;
			$display("error at %0t: apDone = %b, expected 0", $time, apDone);
		end
		assert (apReady === 1'b0) else begin
			errors++;
			$display("error at %0t: apReady = %b, expected 0", $time, apReady);
		end
		assert (resultValid === 1'b0) else begin
			errors++;
			$display("error at %0t: resultValid = %b, expected 0", $time, resultValid);
		end
		assert (memReq.ce === 1'b0) else begin
			errors++;
			$display("error at %0t: memReq.ce = %b, expected 0", $time, memReq.ce);
		end
		assert (result === 16'h0000) else begin
			errors++;
			$display("error at %0t: result = %h, expected 0000", $time, result);
		end
		assert (apIdle === 1'b1) else begin
			errors++;
			$display("error at %0t: apIdle = %b, expected 1", $time, apIdle);
		end
	endtask

	task automatic runLine(input int ln);
		logic [2:0] hold;
		logic holdStart;
		loadMemory(ln);
		@(negedge ap_clk);
		curLine = ln;
		apStart = 1'b1;
		@(negedge ap_clk);
		apStart = 1'b0;
		while (apDone !== 1'b1) @(posedge ap_clk);
		// Random continue delay with start sometimes held high
		hold = '0;
		for (int b = 0; b < 3; b++) begin
			lfsr = lfsrStep(lfsr);
			hold = {hold[1:0], lfsr[0]};
		end
		lfsr = lfsrStep(lfsr);
		holdStart = lfsr[0];
		@(negedge ap_clk);
		apStart = holdStart;
		repeat (hold) @(negedge ap_clk);
		apContinue = 1'b1;
		@(negedge ap_clk);
		apContinue = 1'b0;
		apStart = 1'b0;
	endtask

	// Read data one cycle after ce
	always @(negedge ap_clk) begin
		memData = readPending ? mem[readAddr] : 16'h0000;
	end

	// Run limit checked between clock edges
	always @(negedge ap_clk) begin
		if (cycle >= limit) begin
			$display("Timeout after %0d cycles, the DUT never finished", cycle);
			$display("Simulation failed");
			$finish;
		end
	end

	always @(posedge ap_clk) begin
		if (!ap_rst) begin
			assert (apReady === resultValid) else begin
				errors++;
				$display("error at %0t: apReady = %b, expected %b", $time, apReady,
					resultValid);
			end
			if (donePend) begin
				assert (apDone === 1'b1) else begin
					errors++;
					$display("error at %0t: apDone = %b, expected 1", $time, apDone);
				end
			end else begin
				assert (apDone === resultValid) else begin
					errors++;
					$display("error at %0t: apDone = %b, expected %b", $time, apDone,
						resultValid);
				end
			end
			if (memReq.ce) begin
				assert (busy) else begin
					errors++;
					$display("Memory read issued while no run was active at %0t", $time);
				end
				assert (memReq.addr == expectAddr[3:0]) else begin
					errors++;
					$display("error at %0t: memReq.addr = %0d, expected %0d", $time,
						memReq.addr, expectAddr);
				end
				expectAddr++;
			end
			readPending = memReq.ce;
			readAddr = memReq.addr;
			if (resultValid) begin
				runsSeen++;
				assert (busy) else begin
					errors++;
					$display("resultValid pulsed outside a run at %0t", $time);
				end
				assert (result === expSum[curLine]) else begin
					errors++;
					$display("error at %0t: result = %h, expected %h", $time, result,
						expSum[curLine]);
				end
				assert (expectAddr == NumElems) else begin
					errors++;
					$display("error at %0t: reads = %0d, expected %0d", $time, expectAddr,
						NumElems);
				end
				assert (cycle - startCycle == RunCycles) else begin
					errors++;
					$display("error at %0t: run cycles = %0d, expected %0d", $time,
						cycle - startCycle, RunCycles);
				end
				busy = 1'b0;
				donePend = 1'b1;
			end else if (apStart && !donePend && !busy) begin
				busy = 1'b1; // DUT accepts on this edge
				startCycle = cycle;
				expectAddr = 0;
			end
			if (apContinue) donePend = 1'b0;
		end
		cycle++;
	end

	initial begin
		ap_rst = 1'b1;
		apStart = 1'b0;
		apContinue = 1'b0;
		memData = 16'h0000;
		errors = 0;
		runsSeen = 0;
		cycle = 0;
		curLine = 0;
		startCycle = 0;
		expectAddr = 0;
		busy = 1'b0;
		donePend = 1'b0;
		readAddr = '0;
		lfsr = 32'h1b079dc2;
		readVectors();
		limit = numLines * (1 + NumElems * accumPkg::ElemCycles + 20) + 100;
		repeat (16) @(posedge ap_clk);
		@(negedge ap_clk);
		ap_rst = 1'b0;
		@(posedge ap_clk);
		checkIdleState();
		for (int ln = 0; ln < numLines; ln++) begin
			runLine(ln);
		end
		repeat (4) @(negedge ap_clk);
		assert (runsSeen == numLines && numLines > 0) else begin
			errors++;
			$display("Saw %0d result strobes for %0d data lines", runsSeen, numLines);
		end
		$display("Runs: %0d, errors: %0d", runsSeen, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- hw/vectorAccum.sv
`timescale 1ns/1ps

module vectorAccum #(
	parameter int NumElems = 8 // Words per run, 1 to 15
) (
	input logic ap_clk,
	input logic ap_rst,
	input logic apStart,
	input logic apContinue,
	output logic apDone,
	output logic apIdle,
	output logic apReady,
	output accumPkg::memReqT memReq,
	input halfFloatPkg::halfT memData,
	output halfFloatPkg::halfT result,
	output logic resultValid
);
	halfFloatPkg::halfT opA; // Running sum
	halfFloatPkg::halfT opB; // Latched word
	halfFloatPkg::halfT addSum;

	accumController #(
		.NumElems(NumElems)
	) ctrl (
		.ap_clk(ap_clk),
		.ap_rst(ap_rst),
		.apStart(apStart),
		.apContinue(apContinue),
		.apDone(apDone),
		.apIdle(apIdle),
		.apReady(apReady),
		.memReq(memReq),
		.memData(memData),
		.addSum(addSum),
		.opA(opA),
		.opB(opB),
		.result(result),
		.resultValid(resultValid)
	);

	// Fixed latency, controller counts the cycles
	fpAddPipe adder (
		.ap_clk(ap_clk),
		.opA(opA),
		.opB(opB),
		.sum(addSum)
	);

endmodule

//--- hw/accumController.sv
`timescale 1ns/1ps

module accumController #(
	parameter int NumElems = 8
) (
	input logic ap_clk,
	input logic ap_rst,
	input logic apStart,
	input logic apContinue,
	output logic apDone,
	output logic apIdle,
	output logic apReady,
	output accumPkg::memReqT memReq,
	input halfFloatPkg::halfT memData,
	input halfFloatPkg::halfT addSum,
	output halfFloatPkg::halfT opA,
	output halfFloatPkg::halfT opB,
	output halfFloatPkg::halfT result,
	output logic resultValid
);
	localparam int AddrW = accumPkg::AddrWidth;
	localparam int WaitW = accumPkg::WaitWidth;

	accumPkg::stateT state;
	logic [AddrW-1:0] idx;
	logic [WaitW-1:0] waitCnt;
	logic donePending; // Held until apContinue
	halfFloatPkg::halfT sumReg;
	halfFloatPkg::halfT opBReg;
	halfFloatPkg::halfT resultReg;
	logic startOk;
	logic inFetch;
	logic lastIdx;
	logic endRun;

	// No new run while an old done is unacknowledged
	assign startOk = (state == accumPkg::StIdle) && apStart && !donePending;
	assign inFetch = state == accumPkg::StFetch;
	assign lastIdx = idx == AddrW'(NumElems);
	assign endRun = inFetch && lastIdx;

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			state <= accumPkg::StIdle;
			idx <= '0;
			waitCnt <= '0;
		end else begin
			case (state)
				accumPkg::StIdle: begin
					if (startOk) begin
						state <= accumPkg::StFetch;
						idx <= '0;
					end
				end
				accumPkg::StFetch: state <= endRun ? accumPkg::StIdle : accumPkg::StLatch;
				accumPkg::StLatch: begin
					state <= accumPkg::StWait;
					waitCnt <= '0;
				end
				accumPkg::StWait: begin
					if (waitCnt == WaitW'(accumPkg::AddLatency - 1)) begin
						state <= accumPkg::StFetch;
						idx <= idx + 1'b1; // Next fetch reads the next word
					end else begin
						waitCnt <= waitCnt + 1'b1;
					end
				end
				default: state <= accumPkg::StIdle;
			endcase
		end
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			donePending <= 1'b0;
			resultReg <= '0;
		end else begin
			if (apContinue) begin
				donePending <= 1'b0;
			end else if (endRun) begin
				donePending <= 1'b1;
			end
			if (endRun) begin
				resultReg <= addSum;
			end
		end
	end

	// Previous element's sum lands on addSum in the next fetch
	// Index 0 has nothing in flight, the sum is still the cleared +0
	always_ff @(posedge ap_clk) begin
		if (startOk) begin
			sumReg <= '0;
		end else if (inFetch && idx != '0) begin
			sumReg <= addSum;
		end
		if (state == accumPkg::StLatch) begin
			opBReg <= memData; // Read data valid one cycle after ce
		end
	end

	always_comb begin
		memReq.addr = idx;
		memReq.ce = inFetch && !lastIdx; // No read past the last word
	end

	assign opA = sumReg;
	assign opB = opBReg;

	assign apDone = endRun || donePending;
	assign apReady = endRun;
	assign resultValid = endRun;
	assign apIdle = (state == accumPkg::StIdle) && !apStart;
	assign result = endRun ? addSum : resultReg; // Final sum straight from the adder

endmodule

//--- hw/fpAddPipe.sv
`timescale 1ns/1ps

module fpAddPipe (
	input logic ap_clk,
	input halfFloatPkg::halfT opA,
	input halfFloatPkg::halfT opB,
	output halfFloatPkg::halfT sum
);
	halfFloatPkg::alignedT aligned;
	halfFloatPkg::normT norm;

	// Stage 1
	fpAddAlign alignStage (
		.ap_clk(ap_clk),
		.opA(opA),
		.opB(opB),
		.aligned(aligned)
	);

	// Stages 2 and 3, add then normalize
	fpAddNormalize normStage (
		.ap_clk(ap_clk),
		.aligned(aligned),
		.norm(norm)
	);

	// Stage 4
	fpAddRound roundStage (
		.ap_clk(ap_clk),
		.norm(norm),
		.result(sum)
	);

endmodule

//--- hw/fpAddRound.sv
`timescale 1ns/1ps

module fpAddRound (
	input logic ap_clk,
	input halfFloatPkg::normT norm,
	output halfFloatPkg::halfT result
);
	localparam int ExpW = halfFloatPkg::ExpWidth;
	localparam int ManW = halfFloatPkg::ManWidth;
	localparam int ExpWideW = ExpW + 1;
	localparam int ExpMax = halfFloatPkg::ExpMax;

	halfFloatPkg::halfT resultNext;
	logic roundUp;
	logic roundOf;
	logic [ManW:0] fracUp;
	logic [ManW-1:0] fracOut;
	logic [ExpWideW-1:0] expOut;

	// Nearest, ties to even
	assign roundUp = norm.guard & (norm.round | norm.sticky | norm.frac[0]);
	assign fracUp = {1'b0, norm.frac} + 1'b1;
	assign roundOf = roundUp & fracUp[ManW]; // 1.11..1 rounds up to 10.0
	assign fracOut = roundUp ? fracUp[ManW-1:0] : norm.frac; // Zero on overflow
	assign expOut = norm.exp + ExpWideW'(roundOf);

	always_comb begin
		resultNext.sign = norm.sign;
		resultNext.exp = expOut[ExpW-1:0];
		resultNext.frac = fracOut;
		if (norm.zero) begin
			resultNext = '0; // Always +0
		end else if (expOut >= ExpWideW'(ExpMax)) begin
			resultNext.exp = ExpW'(ExpMax); // Saturate to infinity
			resultNext.frac = '0;
		end
	end

	always_ff @(posedge ap_clk) begin
		result <= resultNext;
	end

endmodule

//--- hw/fpAddNormalize.sv
`timescale 1ns/1ps

module fpAddNormalize (
	input logic ap_clk,
	input halfFloatPkg::alignedT aligned,
	output halfFloatPkg::normT norm
);
	localparam int ExpW = halfFloatPkg::ExpWidth;
	localparam int ManW = halfFloatPkg::ManWidth;
	localparam int GrsW = halfFloatPkg::GrsWidth;
	localparam int RawW = halfFloatPkg::RawWidth;
	localparam int BodyW = RawW - 1; // Raw sum below the carry bit
	localparam int LzW = $clog2(BodyW);
	localparam int ExpWideW = ExpW + 1;

	halfFloatPkg::sumT sumNext;
	halfFloatPkg::sumT sumQ;
	halfFloatPkg::normT normNext;
	logic [RawW-1:0] bigExt;
	logic [RawW-1:0] smallExt;
	logic [BodyW-1:0] body;
	logic [BodyW-1:0] bodyShl;
	logic [LzW-1:0] lz;
	logic [ExpWideW-1:0] expWide;

	// Execute stage
	assign bigExt = {1'b0, aligned.bigSig, {GrsW{1'b0}}};
	assign smallExt = {1'b0, aligned.smallSig};

	always_comb begin
		sumNext.sign = aligned.sign;
		sumNext.exp = aligned.exp;
		// Larger minus smaller, so no borrow out
		sumNext.raw = aligned.effSub ? bigExt - smallExt : bigExt + smallExt;
	end

	always_ff @(posedge ap_clk) begin
		sumQ <= sumNext;
	end

	// Normalize stage
	assign body = sumQ.raw[BodyW-1:0];

	// Leading zero count, highest set bit wins
	always_comb begin
		lz = '0;
		for (int i = 0; i < BodyW; i++) begin
			if (body[i]) begin
				lz = LzW'(BodyW - 1 - i);
			end
		end
	end

	assign bodyShl = body << lz;

	always_comb begin
		normNext.sign = sumQ.sign;
		if (sumQ.raw[RawW-1]) begin
			// Carry out, one step right
			expWide = {1'b0, sumQ.exp} + 1'b1;
			normNext.frac = sumQ.raw[RawW-2 -: ManW];
			normNext.guard = sumQ.raw[GrsW];
			normNext.round = sumQ.raw[GrsW-1];
			normNext.sticky = |sumQ.raw[GrsW-2:0];
		end else begin
			// Left shift, sticky moves up into round
			expWide = {1'b0, sumQ.exp} - ExpWideW'(lz);
			normNext.frac = bodyShl[BodyW-2 -: ManW];
			normNext.guard = bodyShl[GrsW-1];
			normNext.round = bodyShl[GrsW-2];
			normNext.sticky = bodyShl[GrsW-3];
		end
		normNext.exp = expWide;
		// Exact cancellation, or too small for a normal number
		normNext.zero = ~|sumQ.raw | expWide[ExpW] | ~|expWide;
	end

	always_ff @(posedge ap_clk) begin
		norm <= normNext;
	end

endmodule

//--- hw/fpAddAlign.sv
`timescale 1ns/1ps

module fpAddAlign (
	input logic ap_clk,
	input halfFloatPkg::halfT opA,
	input halfFloatPkg::halfT opB,
	output halfFloatPkg::alignedT aligned
);
	localparam int ExpW = halfFloatPkg::ExpWidth;
	localparam int GrsW = halfFloatPkg::GrsWidth;
	localparam int SmallW = halfFloatPkg::SigWidth + GrsW;

	halfFloatPkg::halfT bigOp;
	halfFloatPkg::halfT smallOp;
	halfFloatPkg::alignedT alignNext;
	logic aBig;
	logic [ExpW-1:0] expDiff;
	logic [SmallW-1:0] smallExt;
	logic [SmallW-1:0] shifted;
	logic [SmallW-1:0] lostMask;
	logic sticky;

	// Magnitude only, sign bit left out
	assign aBig = {opA.exp, opA.frac} >= {opB.exp, opB.frac};
	assign bigOp = aBig ? opA : opB;
	assign smallOp = aBig ? opB : opA;
	assign expDiff = bigOp.exp - smallOp.exp; // Never negative here

	// Hidden bit from a nonzero exponent
	// +0 then enters as all zeros
	assign smallExt = {|smallOp.exp, smallOp.frac, {GrsW{1'b0}}};

	assign shifted = smallExt >> expDiff; // Zero once expDiff passes the width
	assign lostMask = ~({SmallW{1'b1}} << expDiff); // Bits that fall off the right
	assign sticky = |(smallExt & lostMask);

	always_comb begin
		alignNext.sign = bigOp.sign; // Equal magnitudes give zero, fixed up later
		alignNext.effSub = opA.sign ^ opB.sign;
		alignNext.exp = bigOp.exp;
		alignNext.bigSig = {|bigOp.exp, bigOp.frac};
		// Everything shifted out folds into the sticky position
		alignNext.smallSig = {shifted[SmallW-1:1], shifted[0] | sticky};
	end

	always_ff @(posedge ap_clk) begin
		aligned <= alignNext;
	end

endmodule

//--- hw/accumPkg.sv
package accumPkg;

	localparam int AddLatency = 4; // fpAddPipe, operands in to sum out
	localparam int ElemCycles = AddLatency + 2; // Fetch and latch come first
	localparam int AddrWidth = 4; // Index has to reach NumElems itself
	localparam int WaitWidth = $clog2(AddLatency);

	// Synchronous read port, data one cycle after ce
	typedef struct packed {
		logic [AddrWidth-1:0] addr;
		logic ce;
	} memReqT;

	// One-hot controller states
	typedef enum logic [3:0] {
		StIdle = 4'b0001,
		StFetch = 4'b0010, // Issue read, or end the run
		StLatch = 4'b0100, // Capture memData
		StWait = 4'b1000 // Adder in flight
	} stateT;

endpackage

//--- hw/halfFloatPkg.sv
package halfFloatPkg;

	// binary16 field widths
	localparam int ExpWidth = 5;
	localparam int ManWidth = 10;
	localparam int ExpBias = 15;
	localparam int GrsWidth = 3; // Guard, round, sticky

	localparam int SigWidth = ManWidth + 1; // Fraction with hidden bit
	localparam int RawWidth = SigWidth + GrsWidth + 1; // Plus carry out of the add
	localparam int ExpMax = 2 * ExpBias + 1; // All ones, infinity

	typedef struct packed {
		logic sign;
		logic [ExpWidth-1:0] exp;
		logic [ManWidth-1:0] frac;
	} halfT;

	// Align stage output
	typedef struct packed {
		logic sign; // Sign of the larger operand
		logic effSub; // Signs differ
		logic [ExpWidth-1:0] exp; // Common exponent
		logic [SigWidth-1:0] bigSig;
		logic [SigWidth+GrsWidth-1:0] smallSig; // Shifted, sticky in the LSB
	} alignedT;

	// Execute stage output
	typedef struct packed {
		logic sign;
		logic [ExpWidth-1:0] exp;
		logic [RawWidth-1:0] raw; // Carry, hidden, fraction, GRS
	} sumT;

	// Normalize stage output
	typedef struct packed {
		logic sign;
		logic [ExpWidth:0] exp; // MSB set means underflow
		logic [ManWidth-1:0] frac;
		logic guard;
		logic round;
		logic sticky;
		logic zero;
	} normT;

endpackage
